// ==== design/nebula_defs.svh ====
/* Team count, widths and address map for the user area.
   Included by every RTL file that sizes ports or decodes addresses. */
`ifndef NEBULA_DEFS_SVH
`define NEBULA_DEFS_SVH

`define NEBULA_NUM_TEAMS 2   // Team slots, source 0 is the idle default
`define NEBULA_GPIO_W    38  // Pads
`define NEBULA_LA_W      32  // Analyzer outputs
`define NEBULA_SRAM_AW   8   // 256 words

// Region field of the bus address
`define NEBULA_REG_HI    15
`define NEBULA_REG_LO    12
`define NEBULA_WORD_HI   11
`define NEBULA_WORD_LO   2

`define NEBULA_REG_SRAM  0
`define NEBULA_REG_GPIO  1
`define NEBULA_REG_LA    2
`define NEBULA_REG_TEAM1 3
`define NEBULA_REG_TEAM2 4

`endif

// ==== design/nebula_ii.sv ====
/* User area top: one Wishbone port reaching the SRAM, two teams and both pin muxes.
   Pads and analyzer outputs come from the muxes. */
`default_nettype none
`include "nebula_defs.svh"

module nebula_ii (
    input  wire                        wb_clk_i,
    input  wire                        arst_n_i,

    // Wishbone from the harness
    input  wire                        wbs_cyc_i,
    input  wire                        wbs_stb_i,
    input  wire                        wbs_we_i,
    input  wire  [3:0]                 wbs_sel_i,
    input  wire  [31:0]                wbs_adr_i,
    input  wire  [31:0]                wbs_dat_i,
    output logic                       wbs_ack_o,
    output logic [31:0]                wbs_dat_o,

    input  wire  [`NEBULA_GPIO_W-1:0]  io_in_i,
    output logic [`NEBULA_GPIO_W-1:0]  io_out_o,
    output logic [`NEBULA_GPIO_W-1:0]  io_oeb_o,   // Active low
    output logic [`NEBULA_LA_W-1:0]    la_data_out_o
);
    import nebula_pkg::*;

    localparam gpio_lane_t GPIO_IDLE = '{out: 1'b0, oeb: 1'b1};  // Pad floating
    localparam la_lane_t   LA_IDLE   = 1'b0;

    gpio_lane_t [`NEBULA_GPIO_W-1:0] team_gpio [1:`NEBULA_NUM_TEAMS];
    la_lane_t [`NEBULA_LA_W-1:0]     team_la [1:`NEBULA_NUM_TEAMS];
    gpio_lane_t [`NEBULA_GPIO_W-1:0] pads;

    wb_if bus_mgr ();
    wb_if bus_sram ();
    wb_if bus_gpio ();
    wb_if bus_la ();
    wb_if bus_team1 ();
    wb_if bus_team2 ();

    assign bus_mgr.cyc   = wbs_cyc_i;
    assign bus_mgr.stb   = wbs_stb_i;
    assign bus_mgr.we    = wbs_we_i;
    assign bus_mgr.sel   = wbs_sel_i;
    assign bus_mgr.adr   = wbs_adr_i;
    assign bus_mgr.dat_w = wbs_dat_i;
    assign wbs_ack_o     = bus_mgr.ack;
    assign wbs_dat_o     = bus_mgr.dat_r;

    wb_decoder i_wb_decoder (
        .wb_clk_i  (wb_clk_i),
        .arst_n_i  (arst_n_i),
        .mgr       (bus_mgr),
        .sram_bus  (bus_sram),
        .gpio_bus  (bus_gpio),
        .la_bus    (bus_la),
        .team1_bus (bus_team1),
        .team2_bus (bus_team2)
    );

    sram_wb i_sram_wb (.wb_clk_i(wb_clk_i), .arst_n_i(arst_n_i), .bus(bus_sram));

    team_sample i_team1 (
        .wb_clk_i  (wb_clk_i),
        .arst_n_i  (arst_n_i),
        .bus       (bus_team1),
        .gpio_in_i (io_in_i),
        .gpio_o    (team_gpio[1]),
        .la_o      (team_la[1])
    );

    team_sample i_team2 (
        .wb_clk_i  (wb_clk_i),
        .arst_n_i  (arst_n_i),
        .bus       (bus_team2),
        .gpio_in_i (io_in_i),
        .gpio_o    (team_gpio[2]),
        .la_o      (team_la[2])
    );

    pin_mux_ctrl #(
        .lane_t  (gpio_lane_t),
        .N_LANES (`NEBULA_GPIO_W)
    ) i_gpio_mux (
        .wb_clk_i     (wb_clk_i),
        .arst_n_i     (arst_n_i),
        .bus          (bus_gpio),
        .team_lanes_i (team_gpio),
        .idle_lane_i  (GPIO_IDLE),
        .lanes_o      (pads)
    );

    pin_mux_ctrl #(
        .lane_t  (la_lane_t),
        .N_LANES (`NEBULA_LA_W)
    ) i_la_mux (
        .wb_clk_i     (wb_clk_i),
        .arst_n_i     (arst_n_i),
        .bus          (bus_la),
        .team_lanes_i (team_la),
        .idle_lane_i  (LA_IDLE),
        .lanes_o      (la_data_out_o)
    );

    // Split pad lanes into the harness pins
    always_comb begin
        for (int n = 0; n < `NEBULA_GPIO_W; n++) begin
            io_out_o[n] = pads[n].out;
            io_oeb_o[n] = pads[n].oeb;
        end
    end

endmodule

`default_nettype wire

// ==== design/nebula_pkg.sv ====
/* Lane payload and select types shared by the pin muxes, the teams and the top */
`default_nettype none

package nebula_pkg;

    // One pad as seen by the pin mux
    typedef struct packed {
        logic out;
        logic oeb;  // Active low output enable
    } gpio_lane_t;

    // One analyzer output bit
    typedef logic la_lane_t;

    // Lane source index, 0 selects the idle value
    typedef logic [3:0] src_sel_t;

endpackage

`default_nettype wire

// ==== design/pin_mux_ctrl.sv ====
/* Per-lane source select registers plus the lane multiplexer.
   Serves the pads and the analyzer through the lane_t type parameter. */
`default_nettype none
`include "nebula_defs.svh"

module pin_mux_ctrl #(
    parameter type lane_t  = nebula_pkg::la_lane_t,
    parameter int  N_LANES = `NEBULA_LA_W
) (
    input  wire                      wb_clk_i,
    input  wire                      arst_n_i,
    wb_if.periph                     bus,
    input  lane_t [N_LANES-1:0]      team_lanes_i [1:`NEBULA_NUM_TEAMS],
    input  lane_t                    idle_lane_i,
    output lane_t [N_LANES-1:0]      lanes_o
);
    import nebula_pkg::*;

    src_sel_t                                  sel_q [N_LANES];
    logic [`NEBULA_WORD_HI:`NEBULA_WORD_LO]    widx;
    logic                                      req;
    logic                                      ack_q;
    logic [31:0]                               rd_word;
    logic [31:0]                               rdat_q;

    assign widx = bus.adr[`NEBULA_WORD_HI:`NEBULA_WORD_LO];
    assign req  = bus.cyc & bus.stb & ~ack_q;

    // Eight nibbles per word, lane l in word l/8
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
            for (int l = 0; l < N_LANES; l++) begin
                sel_q[l] <= '0;
            end
        end else begin
            ack_q <= req;
            if (req && bus.we) begin
                for (int l = 0; l < N_LANES; l++) begin
                    if (int'(widx) == l / 8 && bus.sel[(l % 8) / 2]) begin
                        sel_q[l] <= bus.dat_w[4*(l % 8) +: 4];
                    end
                end
            end
        end
    end

    always_comb begin
        rd_word = '0;  // Nibbles past the last lane read zero
        for (int l = 0; l < N_LANES; l++) begin
            if (int'(widx) == l / 8) begin
                rd_word[4*(l % 8) +: 4] = sel_q[l];
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (req) begin
            rdat_q <= rd_word;
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = rdat_q;

    // Out of range selects fall back to idle
    always_comb begin
        for (int l = 0; l < N_LANES; l++) begin
            lanes_o[l] = idle_lane_i;
            for (int t = 1; t <= `NEBULA_NUM_TEAMS; t++) begin
                if (int'(sel_q[l]) == t) begin
                    lanes_o[l] = team_lanes_i[t][l];
                end
            end
        end
    end

    a_ack_after_req: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        bus.ack |-> $past(bus.cyc && bus.stb));

endmodule

`default_nettype wire

// ==== design/sram_wb.sv ====
/* Scratch memory of 256 words on Wishbone, byte writable through sel */
`default_nettype none
`include "nebula_defs.svh"

module sram_wb (
    input  wire   wb_clk_i,
    input  wire   arst_n_i,
    wb_if.periph  bus
);
    localparam int DEPTH = 1 << `NEBULA_SRAM_AW;

    logic [31:0]                mem [DEPTH];
    logic [`NEBULA_SRAM_AW-1:0] idx;
    logic                       req;
    logic                       ack_q;
    logic [31:0]                rdat_q;

    assign idx = bus.adr[`NEBULA_WORD_LO +: `NEBULA_SRAM_AW];  // Upper word bits alias
    assign req = bus.cyc & bus.stb & ~ack_q;

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (req) begin
            rdat_q <= mem[idx];  // Old contents on a write
            if (bus.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus.sel[b]) begin
                        mem[idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
                    end
                end
            end
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = rdat_q;

    a_ack_single: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        bus.ack |=> !bus.ack);

endmodule

`default_nettype wire

// ==== design/team_sample.sv ====
/* Stand-in team design with OUT and OE registers driving pads and analyzer.
   Word 2 reads back the low pad inputs. */
`default_nettype none
`include "nebula_defs.svh"

module team_sample (
    input  wire                                         wb_clk_i,
    input  wire                                         arst_n_i,
    wb_if.periph                                        bus,
    input  wire [`NEBULA_GPIO_W-1:0]                    gpio_in_i,
    output nebula_pkg::gpio_lane_t [`NEBULA_GPIO_W-1:0] gpio_o,
    output nebula_pkg::la_lane_t [`NEBULA_LA_W-1:0]     la_o
);
    logic [`NEBULA_WORD_HI:`NEBULA_WORD_LO] widx;
    logic                                   req;
    logic                                   ack_q;
    logic [31:0]                            out_q;
    logic [31:0]                            oe_q;
    logic [31:0]                            rdat_q;

    assign widx = bus.adr[`NEBULA_WORD_HI:`NEBULA_WORD_LO];
    assign req  = bus.cyc & bus.stb & ~ack_q;

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
            out_q <= '0;
            oe_q  <= '0;
        end else begin
            ack_q <= req;
            for (int b = 0; b < 4; b++) begin
                if (req && bus.we && bus.sel[b]) begin
                    if (widx == 0) out_q[8*b +: 8] <= bus.dat_w[8*b +: 8];
                    if (widx == 1) oe_q[8*b +: 8]  <= bus.dat_w[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (req) begin
            case (widx)
                0:       rdat_q <= out_q;
                1:       rdat_q <= oe_q;
                2:       rdat_q <= gpio_in_i[31:0];  // Read-only
                default: rdat_q <= '0;
            endcase
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = rdat_q;

    // Pads above 31 wrap onto the low register bits
    always_comb begin
        for (int n = 0; n < `NEBULA_GPIO_W; n++) begin
            gpio_o[n].out = out_q[n % 32];
            gpio_o[n].oeb = ~oe_q[n % 32];
        end
    end

    assign la_o = out_q ^ oe_q;

endmodule

`default_nettype wire

// ==== design/wb_decoder.sv ====
/* Address decoder from the single Wishbone manager to the five targets.
   Unmapped regions get a one-cycle ack with zero read data. */
`default_nettype none
`include "nebula_defs.svh"

module wb_decoder (
    input  wire      wb_clk_i,
    input  wire      arst_n_i,
    wb_if.periph     mgr,
    wb_if.manager    sram_bus,
    wb_if.manager    gpio_bus,
    wb_if.manager    la_bus,
    wb_if.manager    team1_bus,
    wb_if.manager    team2_bus
);
    localparam int N_TGT = `NEBULA_REG_TEAM2 + 1;

    logic [3:0]       region;
    logic [N_TGT-1:0] tgt;      // One-hot target or empty when unmapped
    logic [N_TGT-1:0] tgt_ack;
    logic [31:0]      tgt_dat [N_TGT];
    logic             um_ack_q;

    assign region = mgr.adr[`NEBULA_REG_HI:`NEBULA_REG_LO];

    always_comb begin
        for (int i = 0; i < N_TGT; i++) begin
            tgt[i] = (int'(region) == i);
        end
    end

    assign sram_bus.cyc   = mgr.cyc & tgt[`NEBULA_REG_SRAM];
    assign sram_bus.stb   = mgr.stb & tgt[`NEBULA_REG_SRAM];
    assign sram_bus.we    = mgr.we;
    assign sram_bus.sel   = mgr.sel;
    assign sram_bus.adr   = mgr.adr;
    assign sram_bus.dat_w = mgr.dat_w;
    assign tgt_ack[`NEBULA_REG_SRAM] = sram_bus.ack;
    assign tgt_dat[`NEBULA_REG_SRAM] = sram_bus.dat_r;

    assign gpio_bus.cyc   = mgr.cyc & tgt[`NEBULA_REG_GPIO];
    assign gpio_bus.stb   = mgr.stb & tgt[`NEBULA_REG_GPIO];
    assign gpio_bus.we    = mgr.we;
    assign gpio_bus.sel   = mgr.sel;
    assign gpio_bus.adr   = mgr.adr;
    assign gpio_bus.dat_w = mgr.dat_w;
    assign tgt_ack[`NEBULA_REG_GPIO] = gpio_bus.ack;
    assign tgt_dat[`NEBULA_REG_GPIO] = gpio_bus.dat_r;

    assign la_bus.cyc     = mgr.cyc & tgt[`NEBULA_REG_LA];
    assign la_bus.stb     = mgr.stb & tgt[`NEBULA_REG_LA];
    assign la_bus.we      = mgr.we;
    assign la_bus.sel     = mgr.sel;
    assign la_bus.adr     = mgr.adr;
    assign la_bus.dat_w   = mgr.dat_w;
    assign tgt_ack[`NEBULA_REG_LA] = la_bus.ack;
    assign tgt_dat[`NEBULA_REG_LA] = la_bus.dat_r;

    assign team1_bus.cyc   = mgr.cyc & tgt[`NEBULA_REG_TEAM1];
    assign team1_bus.stb   = mgr.stb & tgt[`NEBULA_REG_TEAM1];
    assign team1_bus.we    = mgr.we;
    assign team1_bus.sel   = mgr.sel;
    assign team1_bus.adr   = mgr.adr;
    assign team1_bus.dat_w = mgr.dat_w;
    assign tgt_ack[`NEBULA_REG_TEAM1] = team1_bus.ack;
    assign tgt_dat[`NEBULA_REG_TEAM1] = team1_bus.dat_r;

    assign team2_bus.cyc   = mgr.cyc & tgt[`NEBULA_REG_TEAM2];
    assign team2_bus.stb   = mgr.stb & tgt[`NEBULA_REG_TEAM2];
    assign team2_bus.we    = mgr.we;
    assign team2_bus.sel   = mgr.sel;
    assign team2_bus.adr   = mgr.adr;
    assign team2_bus.dat_w = mgr.dat_w;
    assign tgt_ack[`NEBULA_REG_TEAM2] = team2_bus.ack;
    assign tgt_dat[`NEBULA_REG_TEAM2] = team2_bus.dat_r;

    // Nobody home, so answer locally after one cycle
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            um_ack_q <= 1'b0;
        end else begin
            um_ack_q <= mgr.cyc & mgr.stb & ~(|tgt) & ~um_ack_q;
        end
    end

    assign mgr.ack = (|(tgt & tgt_ack)) | um_ack_q;

    always_comb begin
        mgr.dat_r = '0;  // Also the unmapped read value
        for (int i = 0; i < N_TGT; i++) begin
            if (tgt[i]) begin
                mgr.dat_r = tgt_dat[i];
            end
        end
    end

    // A request that reached two targets would show up as two acks
    a_one_responder: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        $onehot0({tgt_ack, um_ack_q}));

    // Targets answer only a request seen on the previous edge
    a_ack_after_req: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        $rose(mgr.ack) |-> $past(mgr.cyc && mgr.stb));

endmodule

`default_nettype wire

// ==== design/wb_if.sv ====
/* Wishbone classic bundle between the decoder and its targets.
   The decoder holds the manager side, each target the periph side. */
`default_nettype none

interface wb_if;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  sel;    // Byte enables
    logic [31:0] adr;
    logic [31:0] dat_w;  // Manager to target
    logic [31:0] dat_r;  // Target to manager
    logic        ack;

    modport manager (
        output cyc, stb, we, sel, adr, dat_w,
        input  dat_r, ack
    );

    modport periph (
        input  cyc, stb, we, sel, adr, dat_w,
        output dat_r, ack
    );
endinterface

`default_nettype wire

// ==== nebula_ii.f ====
+incdir+design
design/nebula_pkg.sv
design/wb_if.sv
design/wb_decoder.sv
design/sram_wb.sv
design/pin_mux_ctrl.sv
design/team_sample.sv
design/nebula_ii.sv
sim/tb_nebula_ii.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the user area and its testbench with Verilator, run, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f nebula_ii.f \
    --top-module tb_nebula_ii -o tb_nebula_ii &&
./obj_dir/tb_nebula_ii | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== sim/tb_nebula_ii.sv ====
/* Testbench for the user area top: random Wishbone traffic checked against a reference model.
   Covers reset state, SRAM, both pin muxes, team readback, unmapped regions and ack timing. */
`default_nettype none
`include "nebula_defs.svh"

module tb_nebula_ii;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int GW          = `NEBULA_GPIO_W;
    localparam int LW          = `NEBULA_LA_W;
    localparam int CYCLE_LIMIT = 5000;  // ~600 transactions of up to 3 cycles, plus margin

    logic          clk;
    logic          arst_n;
    logic          cyc;
    logic          stb;
    logic          we;
    logic [3:0]    sel;
    logic [31:0]   adr;
    logic [31:0]   dat_w;
    logic          ack;
    logic [31:0]   dat_r;
    logic [GW-1:0] io_in;
    logic [GW-1:0] io_out;
    logic [GW-1:0] io_oeb;
    logic [LW-1:0] la_out;

    // Reference model
    logic [31:0] sram_m [256];
    logic [3:0]  sram_known [256];  // Bytes written so far
    logic [3:0]  gpio_sel_m [GW];
    logic [3:0]  la_sel_m [LW];
    logic [31:0] out_m [1:2];
    logic [31:0] oe_m [1:2];

    integer seed;
    int     err_count = 0;
    int     timing_errs = 0;
    int     cycles = 0;
    int     txn_count = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    nebula_ii i_nebula_ii (
        .wb_clk_i      (clk),
        .arst_n_i      (arst_n),
        .wbs_cyc_i     (cyc),
        .wbs_stb_i     (stb),
        .wbs_we_i      (we),
        .wbs_sel_i     (sel),
        .wbs_adr_i     (adr),
        .wbs_dat_i     (dat_w),
        .wbs_ack_o     (ack),
        .wbs_dat_o     (dat_r),
        .io_in_i       (io_in),
        .io_out_o      (io_out),
        .io_oeb_o      (io_oeb),
        .la_data_out_o (la_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, the tests did not finish", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            err_count++;
        end
    endtask

    function automatic int random_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    // Mostly teams 1 and 2 or idle, sometimes an out of range source
    function automatic logic [31:0] random_selects();
        logic [31:0] w;
        for (int k = 0; k < 8; k++) begin
            if (random_below(4) == 3) w[4*k +: 4] = 4'(3 + random_below(13));
            else w[4*k +: 4] = 4'(random_below(3));
        end
        return w;
    endfunction

    function automatic logic [31:0] addr_of(input int region, input int word);
        return {16'h0, 4'(region), 10'(word), 2'b00};
    endfunction

    function automatic logic [31:0] byte_mask(input logic [3:0] s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    // Lane l sits in word l/8, nibble l mod 8, written under byte enable (l mod 8)/2
    function automatic logic [3:0] merge_nibble(input logic [3:0] old, input int lane,
                                                input int word, input logic [31:0] d,
                                                input logic [3:0] s);
        if (word == lane / 8 && s[(lane % 8) / 2]) return d[4*(lane % 8) +: 4];
        return old;
    endfunction

    task automatic model_write(input logic [31:0] a, input logic [31:0] d,
                               input logic [3:0] s);
        int region;
        int word;
        int t;
        region = a[`NEBULA_REG_HI:`NEBULA_REG_LO];
        word   = a[`NEBULA_WORD_HI:`NEBULA_WORD_LO];
        t      = region - `NEBULA_REG_TEAM1 + 1;
        for (int b = 0; b < 4; b++) begin
            if (s[b] && region == `NEBULA_REG_SRAM) begin
                sram_m[word % 256][8*b +: 8] = d[8*b +: 8];
                sram_known[word % 256][b]    = 1'b1;
            end
            if (s[b] && (t == 1 || t == 2)) begin
                if (word == 0) out_m[t][8*b +: 8] = d[8*b +: 8];
                if (word == 1) oe_m[t][8*b +: 8]  = d[8*b +: 8];  // Word 2 is read-only
            end
        end
        for (int l = 0; l < GW; l++) begin
            if (region == `NEBULA_REG_GPIO) gpio_sel_m[l] = merge_nibble(gpio_sel_m[l], l, word, d, s);
        end
        for (int l = 0; l < LW; l++) begin
            if (region == `NEBULA_REG_LA) la_sel_m[l] = merge_nibble(la_sel_m[l], l, word, d, s);
        end
    endtask

    // Expected read data for every region but the SRAM
    function automatic logic [31:0] model_read(input logic [31:0] a);
        int region;
        int word;
        int t;
        logic [31:0] r;
        region = a[`NEBULA_REG_HI:`NEBULA_REG_LO];
        word   = a[`NEBULA_WORD_HI:`NEBULA_WORD_LO];
        t      = region - `NEBULA_REG_TEAM1 + 1;
        r      = '0;
        for (int l = 0; l < GW; l++) begin
            if (region == `NEBULA_REG_GPIO && l / 8 == word) r[4*(l % 8) +: 4] = gpio_sel_m[l];
        end
        for (int l = 0; l < LW; l++) begin
            if (region == `NEBULA_REG_LA && l / 8 == word) r[4*(l % 8) +: 4] = la_sel_m[l];
        end
        if (t == 1 || t == 2) begin
            if (word == 0) r = out_m[t];
            if (word == 1) r = oe_m[t];
            if (word == 2) r = io_in[31:0];
        end
        return r;
    endfunction

    function automatic logic [GW-1:0] exp_io_out();
        logic [GW-1:0] v;
        for (int n = 0; n < GW; n++) begin
            v[n] = (gpio_sel_m[n] == 1 || gpio_sel_m[n] == 2) ? out_m[gpio_sel_m[n]][n % 32] : 1'b0;
        end
        return v;
    endfunction

    function automatic logic [GW-1:0] exp_io_oeb();
        logic [GW-1:0] v;
        for (int n = 0; n < GW; n++) begin
            v[n] = (gpio_sel_m[n] == 1 || gpio_sel_m[n] == 2) ? ~oe_m[gpio_sel_m[n]][n % 32] : 1'b1;
        end
        return v;
    endfunction

    function automatic logic [LW-1:0] exp_la();
        logic [LW-1:0] v;
        int s;
        for (int n = 0; n < LW; n++) begin
            s    = la_sel_m[n];
            v[n] = (s == 1 || s == 2) ? out_m[s][n] ^ oe_m[s][n] : 1'b0;
        end
        return v;
    endfunction

    // One classic cycle, entered and left on a falling edge
    task automatic bus_access(input logic wr, input logic [31:0] a, input logic [31:0] d,
                              input logic [3:0] s, output logic [31:0] rdata);
        int lat;
        int errs_before;
        errs_before = err_count;
        lat         = 0;
        check_value("wbs_ack_o before request", ack, 0);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = a;
        dat_w = d;
        sel   = s;
        do begin
            @(negedge clk);
            lat++;
        end while (!ack && lat < 4);
        if (!ack) begin
            $display("No ack arrived within %0d cycles for address 0x%h", lat, a);
            err_count++;
        end
        check_value("ack latency", lat, 1);
        rdata = dat_r;  // Valid with ack
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        @(negedge clk);
        check_value("wbs_ack_o one cycle after ack", ack, 0);
        timing_errs += err_count - errs_before;
        txn_count++;
    endtask

    task automatic bus_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
        logic [31:0] unused_rd;
        bus_access(1'b1, a, d, s, unused_rd);
        model_write(a, d, s);
    endtask

    task automatic bus_read(input logic [31:0] a, output logic [31:0] rdata);
        bus_access(1'b0, a, '0, 4'hf, rdata);
    endtask

    task automatic report_test(input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name, errs);
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] d;
        int start;
        int w;
        int t;
        int idx;
        int written[$];
        seed   = 4;
        arst_n = 1'b0;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        sel    = '0;
        adr    = '0;
        dat_w  = '0;
        io_in  = '0;
        for (int i = 0; i < 256; i++) begin
            sram_m[i]     = '0;
            sram_known[i] = '0;
        end
        for (int l = 0; l < GW; l++) gpio_sel_m[l] = '0;
        for (int l = 0; l < LW; l++) la_sel_m[l] = '0;
        out_m[1] = '0;
        out_m[2] = '0;
        oe_m[1]  = '0;
        oe_m[2]  = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        start = err_count;
        check_value("io_oeb_o", io_oeb, {GW{1'b1}});
        check_value("io_out_o", io_out, 0);
        check_value("la_data_out_o", la_out, 0);
        for (w = 0; w < 5; w++) begin
            bus_read(addr_of(`NEBULA_REG_GPIO, w), rd);
            check_value("GPIO select word", rd, 0);
        end
        for (w = 0; w < 4; w++) begin
            bus_read(addr_of(`NEBULA_REG_LA, w), rd);
            check_value("LA select word", rd, 0);
        end
        for (t = `NEBULA_REG_TEAM1; t <= `NEBULA_REG_TEAM2; t++) begin
            for (w = 0; w < 2; w++) begin
                bus_read(addr_of(t, w), rd);
                check_value("team register", rd, 0);
            end
        end
        report_test("reset state", err_count - start);

        start = err_count;
        for (int n = 0; n < 200; n++) begin
            w = random_below(1024);  // Word bits above 7 alias
            bus_write(addr_of(`NEBULA_REG_SRAM, w), random_word(), 4'(random_below(16)));
            written.push_back(w % 256);
        end
        for (int n = 0; n < 200; n++) begin
            idx = written[random_below(written.size())];
            bus_read(addr_of(`NEBULA_REG_SRAM, idx + 256 * random_below(4)), rd);
            check_value("SRAM read data", rd & byte_mask(sram_known[idx]),
                        sram_m[idx] & byte_mask(sram_known[idx]));
        end
        report_test("SRAM", err_count - start);

        start = err_count;
        for (int n = 0; n < 60; n++) begin
            if (random_below(3) == 0) begin
                t = `NEBULA_REG_TEAM1 + random_below(2);
                bus_write(addr_of(t, random_below(2)), random_word(), 4'(random_below(16)));
            end else begin
                bus_write(addr_of(`NEBULA_REG_GPIO, random_below(5)), random_selects(),
                          4'(random_below(16)));
            end
            check_value("io_out_o", io_out, exp_io_out());
            check_value("io_oeb_o", io_oeb, exp_io_oeb());
        end
        for (w = 0; w < 5; w++) begin
            bus_read(addr_of(`NEBULA_REG_GPIO, w), rd);
            check_value("GPIO select word", rd, model_read(addr_of(`NEBULA_REG_GPIO, w)));
        end
        report_test("GPIO mux", err_count - start);

        start = err_count;
        for (int n = 0; n < 36; n++) begin
            if (random_below(3) == 0) begin
                t = `NEBULA_REG_TEAM1 + random_below(2);
                bus_write(addr_of(t, random_below(2)), random_word(), 4'(random_below(16)));
            end else begin
                bus_write(addr_of(`NEBULA_REG_LA, random_below(4)), random_selects(),
                          4'(random_below(16)));
            end
            check_value("la_data_out_o", la_out, exp_la());
        end
        for (w = 0; w < 4; w++) begin
            bus_read(addr_of(`NEBULA_REG_LA, w), rd);
            check_value("LA select word", rd, model_read(addr_of(`NEBULA_REG_LA, w)));
        end
        for (int n = 0; n < 4; n++) begin
            d     = random_word();
            io_in = {d[5:0], random_word()};
            for (t = `NEBULA_REG_TEAM1; t <= `NEBULA_REG_TEAM2; t++) begin
                bus_write(addr_of(t, 2), random_word(), 4'hf);  // Ignored by the team
                bus_read(addr_of(t, 2), rd);
                check_value("team pad input word", rd, io_in[31:0]);
            end
        end
        report_test("LA mux and team readback", err_count - start);

        start = err_count;
        for (t = 5; t < 16; t++) begin
            w = random_below(1024);
            bus_write(addr_of(t, w), random_word(), 4'hf);
            bus_read(addr_of(t, w), rd);
            check_value("unmapped read data", rd, 0);
        end
        check_value("io_out_o", io_out, exp_io_out());
        check_value("io_oeb_o", io_oeb, exp_io_oeb());
        check_value("la_data_out_o", la_out, exp_la());
        bus_read(addr_of(`NEBULA_REG_TEAM1, 0), rd);
        check_value("team 1 OUT", rd, model_read(addr_of(`NEBULA_REG_TEAM1, 0)));
        report_test("unmapped regions", err_count - start);

        // Every region, with idle gaps of varying length
        for (int n = 0; n < 30; n++) begin
            bus_read(addr_of(random_below(16), random_below(3)), rd);
            repeat (random_below(3)) @(negedge clk);
        end
        report_test("ack timing", timing_errs);

        $display("Tests run %0d, passed %0d, failed %0d, check errors %0d, transactions %0d",
                 tests_run, tests_run - tests_failed, tests_failed, err_count, txn_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
